// ==== cpu_core.f ====
+incdir+hw
hw/cpu_pkg.sv
hw/instr_decode.sv
hw/microcode_exec.sv
hw/result_unit.sv
hw/cpu_core.sv
testbench/tb_cpu_core.sv

// ==== hw/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// ==============================
// Datapath sizing
// ==============================
`define CPU_DATA_WIDTH 8      // Registers, ALU and memory bytes
`define CPU_ADDR_WIDTH 16     // PC and jump targets, two bytes

// ==============================
// Sequencer
// ==============================
`define CPU_NUM_MICROSTEPS 4  // Microsteps available per opcode

// First fetch address after reset
`define CPU_RESET_VECTOR 0

`endif

// ==== hw/cpu_core.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_core (
    input  logic                       clk,
    input  logic                       reset,
    output logic                       req_valid,
    input  logic                       req_ready,
    output logic [`CPU_ADDR_WIDTH-1:0] req_addr,
    input  logic                       rsp_valid,
    input  logic [`CPU_DATA_WIDTH-1:0] rsp_data,
    output logic                       wb_valid,
    input  logic                       wb_ready,
    output cpu_pkg::reg_sel_t          wb_reg,
    output logic [`CPU_DATA_WIDTH-1:0] wb_data,
    output logic                       wb_zero,
    output logic                       halted
);

    // ==============================
    // Decode to execute
    // ==============================
    logic                       dec_valid;
    logic                       dec_ready;
    cpu_pkg::opcode_t           dec_opcode;
    logic [`CPU_DATA_WIDTH-1:0] dec_imm;
    logic [`CPU_ADDR_WIDTH-1:0] dec_target;
    logic                       redirect_valid;
    logic [`CPU_ADDR_WIDTH-1:0] redirect_target;

    // Execute to result
    logic                       op_valid;
    logic                       op_ready;
    cpu_pkg::alu_op_t           op_alu;
    cpu_pkg::reg_sel_t          op_src;
    cpu_pkg::reg_sel_t          op_dst;
    logic                       op_imm_sel;
    logic [`CPU_DATA_WIDTH-1:0] op_imm;
    logic                       op_load_zero;
    logic                       op_report;
    logic                       zero_flag;

    instr_decode u_decode (.*);

    microcode_exec u_exec (.*);

    result_unit u_result (.*);

endmodule

// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

    // ==============================
    // Instruction set
    // ==============================
    typedef enum logic [7:0] {
        NOP    = 8'h00,
        HLT    = 8'h01,
        LDI_A  = 8'h10,
        LDI_B  = 8'h11,
        LDI_C  = 8'h12,
        MOV_AB = 8'h20,  // A into B
        MOV_AC = 8'h21,
        MOV_BA = 8'h22,
        MOV_BC = 8'h23,
        MOV_CA = 8'h24,
        MOV_CB = 8'h25,
        ADD_B  = 8'h30,
        ADD_C  = 8'h31,
        SUB_B  = 8'h32,
        SUB_C  = 8'h33,
        INR_A  = 8'h34,
        DCR_A  = 8'h35,
        ANA_B  = 8'h40,
        ANA_C  = 8'h41,
        ORA_B  = 8'h42,
        ORA_C  = 8'h43,
        XRA_B  = 8'h44,
        XRA_C  = 8'h45,
        ANI    = 8'h48,
        ORI    = 8'h49,
        XRI    = 8'h4a,
        JMP    = 8'h50,
        JZ     = 8'h51,
        JNZ    = 8'h52
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_PASS, ALU_ADD, ALU_SUB, ALU_INR, ALU_DCR, ALU_AND, ALU_OR, ALU_XOR
    } alu_op_t;

    typedef enum logic [1:0] {
        REG_A = 2'd0,
        REG_B = 2'd1,
        REG_C = 2'd2
    } reg_sel_t;

    // Execute FSM
    typedef enum logic [1:0] {
        EX_IDLE, EX_STEP, EX_WAIT, EX_HALT
    } exec_state_t;

    // Operand bytes following each opcode
    function automatic logic [1:0] operand_bytes(input opcode_t op);
        case (op)
            LDI_A, LDI_B, LDI_C, ANI, ORI, XRI: operand_bytes = 2'd1;
            JMP, JZ, JNZ:                        operand_bytes = 2'd2;  // Low byte first
            default:                             operand_bytes = 2'd0;
        endcase
    endfunction

endpackage

// ==== hw/instr_decode.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module instr_decode (
    input  logic                       clk,
    input  logic                       reset,
    output logic                       req_valid,
    input  logic                       req_ready,
    output logic [`CPU_ADDR_WIDTH-1:0] req_addr,
    input  logic                       rsp_valid,
    input  logic [`CPU_DATA_WIDTH-1:0] rsp_data,
    output logic                       dec_valid,
    input  logic                       dec_ready,
    output cpu_pkg::opcode_t           dec_opcode,
    output logic [`CPU_DATA_WIDTH-1:0] dec_imm,
    output logic [`CPU_ADDR_WIDTH-1:0] dec_target,
    input  logic                       redirect_valid,
    input  logic [`CPU_ADDR_WIDTH-1:0] redirect_target,
    input  logic                       halted
);

    logic [`CPU_ADDR_WIDTH-1:0] pc;       // Next byte to request
    logic [1:0]                 issued;   // On the bus or awaiting a response
    logic [1:0]                 stale;    // Responses still owed to a flushed path
    logic [1:0]                 asm_req;  // Bytes requested for the instruction in assembly
    logic [1:0]                 asm_rcv;  // Bytes received for it
    logic [1:0]                 asm_want;
    logic [1:0]                 iss_base;
    cpu_pkg::opcode_t           asm_op;
    logic [`CPU_DATA_WIDTH-1:0] asm_lo;   // Immediate or target low byte
    logic [`CPU_DATA_WIDTH-1:0] asm_hi;
    logic                       rsp_keep;
    logic                       asm_done;
    logic                       hold_free;
    logic                       issue;

    always_comb begin
        // Only the opcode is wanted until it is known
        asm_want  = (asm_rcv == 2'd0) ? 2'd1 : 2'd1 + cpu_pkg::operand_bytes(asm_op);
        iss_base  = issued - {1'b0, rsp_valid};
        rsp_keep  = rsp_valid && (stale == 2'd0);
        asm_done  = (asm_rcv != 2'd0) && (asm_rcv == asm_want);
        hold_free = !dec_valid || dec_ready;
        issue     = (!req_valid || req_ready) && !halted && !redirect_valid
                    && (iss_base < 2'd2) && (asm_req < asm_want);
    end

    // ==============================
    // Fetch and assembly control
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= `CPU_ADDR_WIDTH'(`CPU_RESET_VECTOR);
            req_valid <= 1'b0;
            issued    <= 2'd0;
            stale     <= 2'd0;
            asm_req   <= 2'd0;
            asm_rcv   <= 2'd0;
            dec_valid <= 1'b0;
        end else begin
            if (issue) begin
                req_valid <= 1'b1;
                pc        <= pc + 1'b1;
            end else if (req_ready) begin
                req_valid <= 1'b0;
            end
            issued <= iss_base + {1'b0, issue};

            if (redirect_valid) begin
                // Everything in flight belongs to the old path
                pc        <= redirect_target;
                stale     <= iss_base;
                asm_req   <= 2'd0;
                asm_rcv   <= 2'd0;
                dec_valid <= 1'b0;
            end else begin
                if (rsp_valid && !rsp_keep)
                    stale <= stale - 2'd1;
                if (asm_done && hold_free) begin
                    dec_valid <= 1'b1;
                    asm_req   <= 2'd0;
                    asm_rcv   <= 2'd0;
                end else begin
                    if (dec_ready)
                        dec_valid <= 1'b0;
                    asm_req <= asm_req + {1'b0, issue};
                    asm_rcv <= asm_rcv + {1'b0, rsp_keep};
                end
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (issue)
            req_addr <= pc;
        if (rsp_keep) begin
            case (asm_rcv)
                2'd0:    asm_op <= cpu_pkg::opcode_t'(rsp_data);
                2'd1:    asm_lo <= rsp_data;
                default: asm_hi <= rsp_data;
            endcase
        end
        if (asm_done && hold_free) begin
            dec_opcode <= asm_op;
            dec_imm    <= asm_lo;
            dec_target <= {asm_hi, asm_lo};
        end
    end

    // Request held until the memory takes it
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        req_valid && !req_ready |=> req_valid && $stable(req_addr));

endmodule

// ==== hw/microcode_exec.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module microcode_exec (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       dec_valid,
    output logic                       dec_ready,
    input  cpu_pkg::opcode_t           dec_opcode,
    input  logic [`CPU_DATA_WIDTH-1:0] dec_imm,
    input  logic [`CPU_ADDR_WIDTH-1:0] dec_target,
    output logic                       op_valid,
    input  logic                       op_ready,
    output cpu_pkg::alu_op_t           op_alu,
    output cpu_pkg::reg_sel_t          op_src,
    output cpu_pkg::reg_sel_t          op_dst,
    output logic                       op_imm_sel,
    output logic [`CPU_DATA_WIDTH-1:0] op_imm,
    output logic                       op_load_zero,
    output logic                       op_report,
    input  logic                       zero_flag,
    output logic                       redirect_valid,
    output logic [`CPU_ADDR_WIDTH-1:0] redirect_target,
    output logic                       halted
);

    localparam int STEP_W = $clog2(`CPU_NUM_MICROSTEPS);

    cpu_pkg::exec_state_t       state;
    cpu_pkg::opcode_t           cur_op;
    logic [`CPU_DATA_WIDTH-1:0] cur_imm;
    logic [STEP_W-1:0]          step;
    cpu_pkg::alu_op_t           uc_alu;
    cpu_pkg::reg_sel_t          uc_src;
    cpu_pkg::reg_sel_t          uc_dst;
    logic                       uc_imm_sel;
    logic                       uc_load_zero;
    logic                       uc_report;
    logic                       uc_has_op;
    logic                       uc_last;
    logic                       uc_check_zero;
    logic                       uc_check_not_zero;
    logic                       uc_jump;
    logic                       uc_halt;
    logic                       cond_fail;

    // ==============================
    // Microcode table
    // ==============================
    function automatic void uc_lookup(
        input  cpu_pkg::opcode_t  op,
        input  logic [STEP_W-1:0] s,
        output cpu_pkg::alu_op_t  alu,
        output cpu_pkg::reg_sel_t src,
        output cpu_pkg::reg_sel_t dst,
        output logic              imm_sel,
        output logic              load_zero,
        output logic              report,
        output logic              has_op,
        output logic              last,
        output logic              check_zero,
        output logic              check_not_zero,
        output logic              jump,
        output logic              halt
    );
        imm_sel        = (cpu_pkg::operand_bytes(op) == 2'd1);  // One byte means immediate
        load_zero      = 1'b0;
        report         = 1'b0;
        has_op         = 1'b0;
        last           = 1'b1;
        check_zero     = 1'b0;
        check_not_zero = 1'b0;
        jump           = 1'b0;
        halt           = 1'b0;

        case (op)
            cpu_pkg::ADD_B, cpu_pkg::ADD_C: alu = cpu_pkg::ALU_ADD;
            cpu_pkg::SUB_B, cpu_pkg::SUB_C: alu = cpu_pkg::ALU_SUB;
            cpu_pkg::INR_A:                 alu = cpu_pkg::ALU_INR;
            cpu_pkg::DCR_A:                 alu = cpu_pkg::ALU_DCR;
            cpu_pkg::ANA_B, cpu_pkg::ANA_C, cpu_pkg::ANI: alu = cpu_pkg::ALU_AND;
            cpu_pkg::ORA_B, cpu_pkg::ORA_C, cpu_pkg::ORI: alu = cpu_pkg::ALU_OR;
            cpu_pkg::XRA_B, cpu_pkg::XRA_C, cpu_pkg::XRI: alu = cpu_pkg::ALU_XOR;
            default:                        alu = cpu_pkg::ALU_PASS;  // LDI and MOV
        endcase

        case (op)
            cpu_pkg::ADD_B, cpu_pkg::SUB_B, cpu_pkg::ANA_B, cpu_pkg::ORA_B, cpu_pkg::XRA_B,
            cpu_pkg::MOV_BA, cpu_pkg::MOV_BC: src = cpu_pkg::REG_B;
            cpu_pkg::ADD_C, cpu_pkg::SUB_C, cpu_pkg::ANA_C, cpu_pkg::ORA_C, cpu_pkg::XRA_C,
            cpu_pkg::MOV_CA, cpu_pkg::MOV_CB: src = cpu_pkg::REG_C;
            default:                          src = cpu_pkg::REG_A;
        endcase

        case (op)
            cpu_pkg::LDI_B, cpu_pkg::MOV_AB, cpu_pkg::MOV_CB: dst = cpu_pkg::REG_B;
            cpu_pkg::LDI_C, cpu_pkg::MOV_AC, cpu_pkg::MOV_BC: dst = cpu_pkg::REG_C;
            default:                                          dst = cpu_pkg::REG_A;
        endcase

        // Sequencing per opcode
        case (op)
            cpu_pkg::NOP: ;  // Single empty step
            cpu_pkg::MOV_AB, cpu_pkg::MOV_AC, cpu_pkg::MOV_BA,
            cpu_pkg::MOV_BC, cpu_pkg::MOV_CA, cpu_pkg::MOV_CB: begin
                has_op = 1'b1;
                report = 1'b1;  // Flag untouched
            end
            cpu_pkg::LDI_A, cpu_pkg::LDI_B, cpu_pkg::LDI_C,
            cpu_pkg::ADD_B, cpu_pkg::ADD_C, cpu_pkg::SUB_B, cpu_pkg::SUB_C,
            cpu_pkg::INR_A, cpu_pkg::DCR_A, cpu_pkg::ANA_B, cpu_pkg::ANA_C,
            cpu_pkg::ORA_B, cpu_pkg::ORA_C, cpu_pkg::XRA_B, cpu_pkg::XRA_C,
            cpu_pkg::ANI, cpu_pkg::ORI, cpu_pkg::XRI: begin
                has_op    = 1'b1;
                report    = 1'b1;
                load_zero = 1'b1;
            end
            cpu_pkg::JMP, cpu_pkg::JZ, cpu_pkg::JNZ: begin
                // Condition on step 0, redirect on step 1
                last           = (s != '0);
                jump           = (s != '0);
                check_zero     = (op == cpu_pkg::JZ) && (s == '0);
                check_not_zero = (op == cpu_pkg::JNZ) && (s == '0);
            end
            default: halt = 1'b1;  // HLT, dropped and unknown opcodes
        endcase
    endfunction

    always_comb begin
        uc_lookup(cur_op, step, uc_alu, uc_src, uc_dst, uc_imm_sel, uc_load_zero, uc_report,
                  uc_has_op, uc_last, uc_check_zero, uc_check_not_zero, uc_jump, uc_halt);
        cond_fail = (uc_check_zero && !zero_flag) || (uc_check_not_zero && zero_flag);
    end

    assign dec_ready      = (state == cpu_pkg::EX_IDLE);
    assign halted         = (state == cpu_pkg::EX_HALT);
    assign redirect_valid = (state == cpu_pkg::EX_STEP) && uc_jump;

    // ==============================
    // Microstep sequencer
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= cpu_pkg::EX_IDLE;
            step     <= '0;
            op_valid <= 1'b0;
        end else begin
            case (state)
                cpu_pkg::EX_IDLE: begin
                    if (dec_valid) begin
                        state <= cpu_pkg::EX_STEP;
                        step  <= '0;
                    end
                end
                cpu_pkg::EX_STEP: begin
                    if (uc_halt)
                        state <= cpu_pkg::EX_HALT;
                    else if (cond_fail)
                        state <= cpu_pkg::EX_IDLE;  // Branch not taken
                    else if (uc_has_op) begin
                        op_valid <= 1'b1;
                        state    <= cpu_pkg::EX_WAIT;
                    end else if (uc_last)
                        state <= cpu_pkg::EX_IDLE;
                    else
                        step <= step + 1'b1;
                end
                cpu_pkg::EX_WAIT: begin
                    if (op_ready) begin
                        op_valid <= 1'b0;
                        if (uc_last)
                            state <= cpu_pkg::EX_IDLE;
                        else begin
                            step  <= step + 1'b1;
                            state <= cpu_pkg::EX_STEP;
                        end
                    end
                end
                default: state <= cpu_pkg::EX_HALT;  // Stays until reset
            endcase
        end
    end

    // Instruction and micro-op payload
    always_ff @(posedge clk) begin
        if (dec_valid && dec_ready) begin
            cur_op          <= dec_opcode;
            cur_imm         <= dec_imm;
            redirect_target <= dec_target;
        end
        if (state == cpu_pkg::EX_STEP && uc_has_op) begin
            op_alu       <= uc_alu;
            op_src       <= uc_src;
            op_dst       <= uc_dst;
            op_imm_sel   <= uc_imm_sel;
            op_imm       <= cur_imm;
            op_load_zero <= uc_load_zero;
            op_report    <= uc_report;
        end
    end

    // Redirect only from a jump taken two cycles earlier
    a_redirect_jump: assert property (@(posedge clk) disable iff (reset)
        redirect_valid |-> $past(dec_valid && dec_ready, 2)
            && ($past(dec_opcode, 2) inside {cpu_pkg::JMP, cpu_pkg::JZ, cpu_pkg::JNZ}));

endmodule

// ==== hw/result_unit.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module result_unit (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       op_valid,
    output logic                       op_ready,
    input  cpu_pkg::alu_op_t           op_alu,
    input  cpu_pkg::reg_sel_t          op_src,
    input  cpu_pkg::reg_sel_t          op_dst,
    input  logic                       op_imm_sel,
    input  logic [`CPU_DATA_WIDTH-1:0] op_imm,
    input  logic                       op_load_zero,
    input  logic                       op_report,
    output logic                       zero_flag,
    output logic                       wb_valid,
    input  logic                       wb_ready,
    output cpu_pkg::reg_sel_t          wb_reg,
    output logic [`CPU_DATA_WIDTH-1:0] wb_data,
    output logic                       wb_zero
);

    logic [`CPU_DATA_WIDTH-1:0] reg_a;
    logic [`CPU_DATA_WIDTH-1:0] reg_b;
    logic [`CPU_DATA_WIDTH-1:0] reg_c;
    logic [`CPU_DATA_WIDTH-1:0] opnd_a;   // Destination register value
    logic [`CPU_DATA_WIDTH-1:0] src_val;
    logic [`CPU_DATA_WIDTH-1:0] opnd_b;
    logic [`CPU_DATA_WIDTH-1:0] alu_res;
    logic                       res_zero;
    logic                       op_fire;

    // Stall while a writeback is unaccepted
    assign op_ready = !wb_valid || wb_ready;
    assign op_fire  = op_valid && op_ready;

    // ==============================
    // Operand select and ALU
    // ==============================
    always_comb begin
        case (op_dst)
            cpu_pkg::REG_B: opnd_a = reg_b;
            cpu_pkg::REG_C: opnd_a = reg_c;
            default:        opnd_a = reg_a;
        endcase
        case (op_src)
            cpu_pkg::REG_B: src_val = reg_b;
            cpu_pkg::REG_C: src_val = reg_c;
            default:        src_val = reg_a;
        endcase
        opnd_b = op_imm_sel ? op_imm : src_val;

        case (op_alu)
            cpu_pkg::ALU_ADD: alu_res = opnd_a + opnd_b;  // Wraps
            cpu_pkg::ALU_SUB: alu_res = opnd_a - opnd_b;
            cpu_pkg::ALU_INR: alu_res = opnd_a + 1'b1;
            cpu_pkg::ALU_DCR: alu_res = opnd_a - 1'b1;
            cpu_pkg::ALU_AND: alu_res = opnd_a & opnd_b;
            cpu_pkg::ALU_OR:  alu_res = opnd_a | opnd_b;
            cpu_pkg::ALU_XOR: alu_res = opnd_a ^ opnd_b;
            default:          alu_res = opnd_b;           // Pass second operand
        endcase
        res_zero = (alu_res == '0);
    end

    // Register file, flag and writeback handshake
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_a     <= '0;
            reg_b     <= '0;
            reg_c     <= '0;
            zero_flag <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            if (op_fire) begin
                case (op_dst)
                    cpu_pkg::REG_A: reg_a <= alu_res;
                    cpu_pkg::REG_B: reg_b <= alu_res;
                    cpu_pkg::REG_C: reg_c <= alu_res;
                    default: ;
                endcase
                if (op_load_zero)
                    zero_flag <= res_zero;
            end
            if (op_fire && op_report)
                wb_valid <= 1'b1;
            else if (wb_ready)
                wb_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (op_fire && op_report) begin
            wb_reg  <= op_dst;
            wb_data <= alu_res;
            wb_zero <= op_load_zero ? res_zero : zero_flag;  // MOV reports the old flag
        end
    end

    a_wb_stable: assert property (@(posedge clk) disable iff (reset)
        wb_valid && !wb_ready |=> wb_valid && $stable({wb_reg, wb_data, wb_zero}));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f cpu_core.f --top-module tb_cpu_core -o sim_cpu_core \
    && ./obj_dir/sim_cpu_core | tee /dev/stderr \
    | grep -q "Simulation completed successfully" \
    && echo "run_sim: PASS" \
    || { echo "run_sim: FAIL"; exit 1; }

// ==== testbench/tb_cpu_core.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module tb_cpu_core;

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 5;
    localparam int MEM_BYTES       = 256;
    localparam int CYCLES_PER_BYTE = 80;
    localparam int QUIET_CYCLES    = 20;    // Watch time after halt
    localparam logic [7:0] DROPPED_ADC = 8'h36;  // Old ADC slot, now undefined

    logic                       clk;
    logic                       reset;
    logic                       req_valid;
    logic                       req_ready;
    logic [`CPU_ADDR_WIDTH-1:0] req_addr;
    logic                       rsp_valid;
    logic [`CPU_DATA_WIDTH-1:0] rsp_data;
    logic                       wb_valid;
    logic                       wb_ready;
    cpu_pkg::reg_sel_t          wb_reg;
    logic [`CPU_DATA_WIDTH-1:0] wb_data;
    logic                       wb_zero;
    logic                       halted;

    logic [`CPU_DATA_WIDTH-1:0] mem [0:MEM_BYTES-1];
    logic [`CPU_DATA_WIDTH-1:0] prog [$];
    logic [`CPU_ADDR_WIDTH-1:0] pend_addr [$];   // Accepted requests, oldest first
    int                         pend_due [$];
    cpu_pkg::reg_sel_t          got_reg [$];     // Observed writebacks
    logic [`CPU_DATA_WIDTH-1:0] got_data [$];
    logic                       got_zero [$];

    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     cycle_limit = 0;
    int     mem_cycle = 0;
    bit     stress = 1'b0;  // Random ready and memory delay when set
    bit     in_reset;
    bit     mode;

    cpu_core dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Background bytes outside the program image
    function automatic logic [7:0] fill_byte(input logic [`CPU_ADDR_WIDTH-1:0] addr);
        return addr[7:0] ^ addr[15:8] ^ 8'h5a;
    endfunction

    function automatic logic [7:0] read_byte(input logic [`CPU_ADDR_WIDTH-1:0] addr);
        if (addr < MEM_BYTES)
            return mem[addr];
        return fill_byte(addr);  // Past the image
    endfunction

    // ==============================
    // Memory and writeback models
    // ==============================
    always begin
        @(posedge clk);
        mem_cycle++;
        in_reset = reset;
        mode     = stress;
        if (in_reset) begin
            pend_addr.delete();
            pend_due.delete();
        end else begin
            if (req_valid && req_ready) begin
                pend_addr.push_back(req_addr);
                pend_due.push_back(mem_cycle + (mode ? ($random(seed) & 3) : 0));
            end
            if (wb_valid && wb_ready) begin
                got_reg.push_back(wb_reg);
                got_data.push_back(wb_data);
                got_zero.push_back(wb_zero);
            end
        end
        #1;
        rsp_valid = 1'b0;
        if (!in_reset && pend_due.size() != 0 && pend_due[0] <= mem_cycle) begin
            rsp_valid = 1'b1;
            rsp_data  = read_byte(pend_addr.pop_front());
            void'(pend_due.pop_front());
        end
        req_ready = !mode || (($random(seed) & 3) != 0);
        wb_ready  = !mode || (($random(seed) & 3) != 0);
    end

    // Limit grows by the byte count of each program loaded
    initial begin
        while (cycles <= cycle_limit) begin
            @(posedge clk);
            if (!reset)
                cycles++;
        end
        $display("Timeout: the DUT did not finish within %0d cycles", cycle_limit);
        $display("Simulation failed");
        $finish;
    end

    // ==============================
    // Program building and checks
    // ==============================
    task automatic put_op(input logic [7:0] op);
        prog.push_back(op);
    endtask

    task automatic with_imm(input logic [7:0] op, input logic [7:0] imm);
        prog.push_back(op);
        prog.push_back(imm);
    endtask

    task automatic jump_to(input logic [7:0] op, input logic [15:0] target);
        prog.push_back(op);
        prog.push_back(target[7:0]);  // Low byte first
        prog.push_back(target[15:8]);
    endtask

    task automatic start_program;
        @(posedge clk);
        #1;
        reset = 1'b1;
        for (int i = 0; i < MEM_BYTES; i++)
            mem[i] = fill_byte(i[`CPU_ADDR_WIDTH-1:0]);
        foreach (prog[i])
            mem[i] = prog[i];
        cycle_limit += CYCLES_PER_BYTE * prog.size();
        repeat (RESET_CYCLES) @(posedge clk);
        got_reg.delete();
        got_data.delete();
        got_zero.delete();
        #1;
        reset = 1'b0;
    endtask

    task automatic check_wb(input cpu_pkg::reg_sel_t exp_reg, input logic [7:0] exp_data,
                            input logic exp_zero);
        cpu_pkg::reg_sel_t r;
        logic [7:0]        d;
        logic              z;
        while (got_reg.size() == 0)
            @(negedge clk);
        r = got_reg.pop_front();
        d = got_data.pop_front();
        z = got_zero.pop_front();
        checks++;
        if (r !== exp_reg || d !== exp_data || z !== exp_zero) begin
            errors++;
            $display("ERROR at %0t: writeback %s=%h zero=%b, expected %s=%h zero=%b",
                     $time, r.name(), d, z, exp_reg.name(), exp_data, exp_zero);
        end
    endtask

    task automatic check_halt;
        while (!halted)
            @(negedge clk);
        repeat (QUIET_CYCLES) @(negedge clk);
        checks++;
        if (halted !== 1'b1) begin
            errors++;
            $display("ERROR at %0t: halted dropped before reset", $time);
        end
        if (got_reg.size() != 0) begin
            errors++;
            $display("ERROR at %0t: %0d writebacks after halt", $time, got_reg.size());
        end
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic load_and_move;
        prog.delete();
        stress = 1'b0;
        with_imm(cpu_pkg::LDI_B, 8'h3c);
        with_imm(cpu_pkg::LDI_C, 8'h81);
        with_imm(cpu_pkg::LDI_A, 8'h00);  // Zero flag set for the moves
        put_op(cpu_pkg::MOV_BA);
        put_op(cpu_pkg::MOV_CB);
        put_op(cpu_pkg::MOV_AC);
        put_op(cpu_pkg::MOV_BC);
        put_op(cpu_pkg::MOV_CA);
        put_op(cpu_pkg::MOV_AB);
        with_imm(cpu_pkg::LDI_A, 8'h07);
        put_op(cpu_pkg::MOV_AB);  // Now the flag is clear
        put_op(cpu_pkg::HLT);
        start_program();
        check_wb(cpu_pkg::REG_B, 8'h3c, 1'b0);
        check_wb(cpu_pkg::REG_C, 8'h81, 1'b0);
        check_wb(cpu_pkg::REG_A, 8'h00, 1'b1);
        check_wb(cpu_pkg::REG_A, 8'h3c, 1'b1);
        check_wb(cpu_pkg::REG_B, 8'h81, 1'b1);
        check_wb(cpu_pkg::REG_C, 8'h3c, 1'b1);
        check_wb(cpu_pkg::REG_C, 8'h81, 1'b1);
        check_wb(cpu_pkg::REG_A, 8'h81, 1'b1);
        check_wb(cpu_pkg::REG_B, 8'h81, 1'b1);
        check_wb(cpu_pkg::REG_A, 8'h07, 1'b0);
        check_wb(cpu_pkg::REG_B, 8'h07, 1'b0);
        check_halt();
    endtask

    task automatic arith_sequence(input bit random_timing);
        prog.delete();
        stress = random_timing;
        with_imm(cpu_pkg::LDI_A, 8'hf0);
        with_imm(cpu_pkg::LDI_B, 8'h10);
        put_op(cpu_pkg::ADD_B);           // f0 + 10 wraps to 00
        with_imm(cpu_pkg::LDI_C, 8'h05);
        put_op(cpu_pkg::SUB_C);
        put_op(cpu_pkg::ADD_C);
        put_op(cpu_pkg::DCR_A);
        put_op(cpu_pkg::INR_A);           // ff + 1 wraps
        put_op(cpu_pkg::INR_A);
        put_op(cpu_pkg::SUB_B);
        with_imm(cpu_pkg::LDI_B, 8'hf1);
        put_op(cpu_pkg::SUB_B);
        put_op(cpu_pkg::HLT);
        start_program();
        check_wb(cpu_pkg::REG_A, 8'hf0, 1'b0);
        check_wb(cpu_pkg::REG_B, 8'h10, 1'b0);
        check_wb(cpu_pkg::REG_A, 8'h00, 1'b1);
        check_wb(cpu_pkg::REG_C, 8'h05, 1'b0);
        check_wb(cpu_pkg::REG_A, 8'hfb, 1'b0);
        check_wb(cpu_pkg::REG_A, 8'h00, 1'b1);
        check_wb(cpu_pkg::REG_A, 8'hff, 1'b0);
        check_wb(cpu_pkg::REG_A, 8'h00, 1'b1);
        check_wb(cpu_pkg::REG_A, 8'h01, 1'b0);
        check_wb(cpu_pkg::REG_A, 8'hf1, 1'b0);
        check_wb(cpu_pkg::REG_B, 8'hf1, 1'b0);
        check_wb(cpu_pkg::REG_A, 8'h00, 1'b1);
        check_halt();
    endtask

    task automatic logic_ops;
        prog.delete();
        stress = 1'b0;
        with_imm(cpu_pkg::LDI_A, 8'hcc);
        with_imm(cpu_pkg::LDI_B, 8'haa);
        with_imm(cpu_pkg::LDI_C, 8'h0f);
        put_op(cpu_pkg::ANA_B);
        put_op(cpu_pkg::ORA_C);
        put_op(cpu_pkg::XRA_B);
        put_op(cpu_pkg::ANA_C);
        put_op(cpu_pkg::XRA_C);
        put_op(cpu_pkg::ORA_B);
        with_imm(cpu_pkg::ANI, 8'h55);
        with_imm(cpu_pkg::ORI, 8'h30);
        with_imm(cpu_pkg::XRI, 8'h30);
        put_op(cpu_pkg::HLT);
        start_program();
        check_wb(cpu_pkg::REG_A, 8'hcc, 1'b0);
        check_wb(cpu_pkg::REG_B, 8'haa, 1'b0);
        check_wb(cpu_pkg::REG_C, 8'h0f, 1'b0);
        check_wb(cpu_pkg::REG_A, 8'h88, 1'b0);
        check_wb(cpu_pkg::REG_A, 8'h8f, 1'b0);
        check_wb(cpu_pkg::REG_A, 8'h25, 1'b0);
        check_wb(cpu_pkg::REG_A, 8'h05, 1'b0);
        check_wb(cpu_pkg::REG_A, 8'h0a, 1'b0);
        check_wb(cpu_pkg::REG_A, 8'haa, 1'b0);
        check_wb(cpu_pkg::REG_A, 8'h00, 1'b1);
        check_wb(cpu_pkg::REG_A, 8'h30, 1'b0);
        check_wb(cpu_pkg::REG_A, 8'h00, 1'b1);
        check_halt();
    endtask

    task automatic jump_paths;
        prog.delete();
        stress = 1'b0;
        with_imm(cpu_pkg::LDI_A, 8'h01);    // 0
        jump_to(cpu_pkg::JMP, 16'd8);       // 2
        with_imm(cpu_pkg::LDI_B, 8'hee);    // 5, skipped
        put_op(cpu_pkg::HLT);               // 7
        jump_to(cpu_pkg::JZ, 16'd14);       // 8, flag clear
        with_imm(cpu_pkg::LDI_B, 8'h22);    // 11
        put_op(cpu_pkg::DCR_A);             // 13
        jump_to(cpu_pkg::JZ, 16'd20);       // 14, flag set
        with_imm(cpu_pkg::LDI_C, 8'hee);    // 17, skipped
        put_op(cpu_pkg::HLT);               // 19
        jump_to(cpu_pkg::JNZ, 16'd26);      // 20, flag set
        with_imm(cpu_pkg::LDI_C, 8'h33);    // 23
        put_op(cpu_pkg::INR_A);             // 25
        jump_to(cpu_pkg::JNZ, 16'd32);      // 26, flag clear
        with_imm(cpu_pkg::LDI_C, 8'hee);    // 29, skipped
        put_op(cpu_pkg::HLT);               // 31
        with_imm(cpu_pkg::LDI_A, 8'h44);    // 32
        put_op(cpu_pkg::HLT);
        start_program();
        check_wb(cpu_pkg::REG_A, 8'h01, 1'b0);
        check_wb(cpu_pkg::REG_B, 8'h22, 1'b0);
        check_wb(cpu_pkg::REG_A, 8'h00, 1'b1);
        check_wb(cpu_pkg::REG_C, 8'h33, 1'b0);
        check_wb(cpu_pkg::REG_A, 8'h01, 1'b0);
        check_wb(cpu_pkg::REG_A, 8'h44, 1'b0);
        check_halt();
    endtask

    task automatic halt_paths;
        prog.delete();
        stress = 1'b0;
        with_imm(cpu_pkg::LDI_A, 8'h09);
        put_op(cpu_pkg::HLT);
        with_imm(cpu_pkg::LDI_B, 8'h77);  // Never reported
        start_program();
        check_wb(cpu_pkg::REG_A, 8'h09, 1'b0);
        check_halt();

        prog.delete();
        with_imm(cpu_pkg::LDI_C, 8'h12);
        put_op(DROPPED_ADC);
        with_imm(cpu_pkg::LDI_A, 8'h66);
        start_program();
        check_wb(cpu_pkg::REG_C, 8'h12, 1'b0);
        check_halt();
    endtask

    initial begin
        seed      = 32'h68cc;
        reset     = 1'b1;
        req_ready = 1'b0;
        rsp_valid = 1'b0;
        rsp_data  = '0;
        wb_ready  = 1'b1;
        load_and_move();
        arith_sequence(1'b0);
        logic_ops();
        jump_paths();
        halt_paths();
        arith_sequence(1'b1);  // Same results under random stalls
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
